//--- Bender.yml
package:
  name: fv_mem

sources:
  - include_dirs:
      - hw
    files:
      - hw/fv_mem_pkg.sv
      - hw/fv_req_fifo.sv
      - hw/fv_mem_dispatch.sv
      - hw/fv_bank_ctrl.sv
      - hw/fv_mem_top.sv
  - target: simulation
    include_dirs:
      - hw
    files:
      - verif/fv_mem_asserts.sv
      - verif/fv_mem_tb.sv

//--- hw/fv_bank_ctrl.sv
// storage is not initialised, so a read of an unwritten word returns unknown data; issue must not arrive while busy.
`include "fv_mem_consts.svh"

module fv_bank_ctrl import fv_mem_pkg::*; (
    input  logic                       clk,
    input  logic                       reset,
    input  logic                       issue_valid,
    input  fv_op_t                     issue_op,
    input  logic [`FV_BANK_ADDR_W-1:0] issue_bank_addr,
    input  logic [`FV_TAG_W-1:0]       issue_tag,
    input  logic [`FV_DATA_W-1:0]      issue_wdata,
    output logic                       busy,
    output logic                       rsp_valid,
    output fv_op_t                     rsp_op,
    output logic [`FV_TAG_W-1:0]       rsp_tag,
    output logic [`FV_DATA_W-1:0]      rsp_data
);

    localparam int DEPTH = 2 ** `FV_BANK_ADDR_W;
    localparam int CNT_W = $clog2(`FV_BANK_LAT + 1);

    logic [`FV_DATA_W-1:0] mem [DEPTH];
    logic [CNT_W-1:0]      cnt;

    // countdown is loaded on issue and stops at zero.
    // the last nonzero value is the response cycle.
    always_ff @(posedge clk) begin
        if (reset) begin
            cnt <= '0;
        end else if (issue_valid) begin
            cnt <= CNT_W'(`FV_BANK_LAT);
        end else if (cnt != '0) begin
            cnt <= cnt - 1'b1;
        end
    end

    assign busy      = (cnt != '0);
    assign rsp_valid = (cnt == CNT_W'(1));

    // the array is accessed on issue and the response is held until it is presented.
    always_ff @(posedge clk) begin
        if (issue_valid) begin
            rsp_op  <= issue_op;
            rsp_tag <= issue_tag;
            if (issue_op == FV_OP_WRITE) begin
                mem[issue_bank_addr] <= issue_wdata;
                rsp_data             <= issue_wdata;
            end else begin
                rsp_data <= mem[issue_bank_addr];
            end
        end
    end

endmodule

//--- hw/fv_mem_consts.svh
// compile-time sizes only; FIFO depth must be a power of two and bank count must be 4 (2-bit bank field).
`ifndef FV_MEM_CONSTS_SVH
`define FV_MEM_CONSTS_SVH

// number of banks sharing the request port.
`define FV_NUM_BANKS 4

// full address is the bank index on top of the in-bank word address.
`define FV_ADDR_W 8
`define FV_BANK_ADDR_W 6

// feature word and processing element tag.
`define FV_DATA_W 32
`define FV_TAG_W 4

// request FIFO entries.
`define FV_FIFO_DEPTH 8

// cycles from issue to response inside a bank.
`define FV_BANK_LAT 3

`endif

//--- hw/fv_mem_dispatch.sv
// one request in flight at a time; relies on bank_busy rising the cycle after each issue.
`include "fv_mem_consts.svh"

module fv_mem_dispatch import fv_mem_pkg::*; (
    input  logic                       clk,
    input  logic                       reset,
    input  logic                       fifo_empty,
    input  logic                       fifo_valid,
    input  fv_op_t                     fifo_op,
    input  logic [`FV_ADDR_W-1:0]      fifo_addr,
    input  logic [`FV_TAG_W-1:0]       fifo_tag,
    input  logic [`FV_DATA_W-1:0]      fifo_wdata,
    input  logic [`FV_NUM_BANKS-1:0]   bank_busy,
    output logic                       fifo_rinc,
    output logic [`FV_NUM_BANKS-1:0]   issue_valid,
    output fv_op_t                     issue_op,
    output logic [`FV_BANK_ADDR_W-1:0] issue_bank_addr,
    output logic [`FV_TAG_W-1:0]       issue_tag,
    output logic [`FV_DATA_W-1:0]      issue_wdata
);

    localparam int BANK_W = $clog2(`FV_NUM_BANKS);

    fv_disp_state_t state;
    fv_disp_state_t nx_state;

    // request held between the FIFO pop and the issue.
    fv_op_t                req_op;
    logic [`FV_ADDR_W-1:0] req_addr;
    logic [`FV_TAG_W-1:0]  req_tag;
    logic [`FV_DATA_W-1:0] req_wdata;

    logic [BANK_W-1:0]        fifo_bank;
    logic [BANK_W-1:0]        req_bank;
    logic                     capture;
    logic                     nx_rinc;
    logic [`FV_NUM_BANKS-1:0] nx_issue_valid;

    assign fifo_bank = fifo_addr[`FV_ADDR_W-1:`FV_BANK_ADDR_W];
    assign req_bank  = req_addr[`FV_ADDR_W-1:`FV_BANK_ADDR_W];

    always_comb begin
        nx_state       = state;
        nx_rinc        = 1'b0;
        nx_issue_valid = '0;
        capture        = 1'b0;
        case (state)
            DISP_IDLE: begin
                if (!fifo_empty) begin
                    nx_rinc  = 1'b1;
                    nx_state = DISP_ROUTE;
                end
            end
            DISP_ROUTE: begin
                // the busy check here uses the bank of the entry arriving now.
                if (fifo_valid) begin
                    capture  = 1'b1;
                    nx_state = bank_busy[fifo_bank] ? DISP_STALL : DISP_COMPLETE;
                end
            end
            DISP_STALL: begin
                if (!bank_busy[req_bank]) nx_state = DISP_COMPLETE;
            end
            DISP_COMPLETE: begin
                nx_issue_valid[req_bank] = 1'b1;
                if (!fifo_empty) begin
                    nx_rinc  = 1'b1;
                    nx_state = DISP_ROUTE;
                end else begin
                    nx_state = DISP_IDLE;
                end
            end
            default: nx_state = DISP_IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state       <= DISP_IDLE;
            fifo_rinc   <= 1'b0;
            issue_valid <= '0;
        end else begin
            state       <= nx_state;
            fifo_rinc   <= nx_rinc;
            issue_valid <= nx_issue_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (capture) begin
            req_op    <= fifo_op;
            req_addr  <= fifo_addr;
            req_tag   <= fifo_tag;
            req_wdata <= fifo_wdata;
        end
        // payload lines up with the registered strobe.
        if (state == DISP_COMPLETE) begin
            issue_op        <= req_op;
            issue_bank_addr <= req_addr[`FV_BANK_ADDR_W-1:0];
            issue_tag       <= req_tag;
            issue_wdata     <= req_wdata;
        end
    end

endmodule

//--- hw/fv_mem_pkg.sv
// shared enums only; encodings are fixed widths and do not follow the constants header.
package fv_mem_pkg;

    // request opcode carried from the port down to each bank.
    typedef enum logic {
        FV_OP_READ  = 1'b0,
        FV_OP_WRITE = 1'b1
    } fv_op_t;

    // dispatcher states.
    // route waits for the popped entry, stall waits for the bank,
    // and complete issues it.
    typedef enum logic [1:0] {
        DISP_IDLE     = 2'd0,
        DISP_ROUTE    = 2'd1,
        DISP_STALL    = 2'd2,
        DISP_COMPLETE = 2'd3
    } fv_disp_state_t;

endpackage

//--- hw/fv_mem_top.sv
// one response port per bank with no merging; the caller must not push while req_full is high.
`include "fv_mem_consts.svh"

module fv_mem_top import fv_mem_pkg::*; (
    input  logic                                 clk,
    input  logic                                 reset,
    input  logic                                 req_push,
    input  fv_op_t                               req_op,
    input  logic [`FV_ADDR_W-1:0]                req_addr,
    input  logic [`FV_TAG_W-1:0]                 req_tag,
    input  logic [`FV_DATA_W-1:0]                req_wdata,
    output logic                                 req_full,
    output logic [`FV_NUM_BANKS-1:0]             rsp_valid,
    output fv_op_t [`FV_NUM_BANKS-1:0]           rsp_op,
    output logic [`FV_NUM_BANKS*`FV_TAG_W-1:0]   rsp_tag,
    output logic [`FV_NUM_BANKS*`FV_DATA_W-1:0]  rsp_data
);

    logic                       fifo_empty;
    logic                       fifo_valid;
    logic                       fifo_rinc;
    fv_op_t                     fifo_op;
    logic [`FV_ADDR_W-1:0]      fifo_addr;
    logic [`FV_TAG_W-1:0]       fifo_tag;
    logic [`FV_DATA_W-1:0]      fifo_wdata;

    logic [`FV_NUM_BANKS-1:0]   bank_busy;
    logic [`FV_NUM_BANKS-1:0]   issue_valid;
    fv_op_t                     issue_op;
    logic [`FV_BANK_ADDR_W-1:0] issue_bank_addr;
    logic [`FV_TAG_W-1:0]       issue_tag;
    logic [`FV_DATA_W-1:0]      issue_wdata;

    fv_req_fifo u_fifo (
        .clk        (clk),
        .reset      (reset),
        .push       (req_push),
        .push_op    (req_op),
        .push_addr  (req_addr),
        .push_tag   (req_tag),
        .push_wdata (req_wdata),
        .rinc       (fifo_rinc),
        .empty      (fifo_empty),
        .full       (req_full),
        .valid      (fifo_valid),
        .rd_op      (fifo_op),
        .rd_addr    (fifo_addr),
        .rd_tag     (fifo_tag),
        .rd_wdata   (fifo_wdata)
    );

    fv_mem_dispatch u_dispatch (
        .clk             (clk),
        .reset           (reset),
        .fifo_empty      (fifo_empty),
        .fifo_valid      (fifo_valid),
        .fifo_op         (fifo_op),
        .fifo_addr       (fifo_addr),
        .fifo_tag        (fifo_tag),
        .fifo_wdata      (fifo_wdata),
        .bank_busy       (bank_busy),
        .fifo_rinc       (fifo_rinc),
        .issue_valid     (issue_valid),
        .issue_op        (issue_op),
        .issue_bank_addr (issue_bank_addr),
        .issue_tag       (issue_tag),
        .issue_wdata     (issue_wdata)
    );

    // all banks share the issue payload and each takes only its own strobe.
    for (genvar i = 0; i < `FV_NUM_BANKS; i++) begin : g_bank
        fv_bank_ctrl u_bank (
            .clk             (clk),
            .reset           (reset),
            .issue_valid     (issue_valid[i]),
            .issue_op        (issue_op),
            .issue_bank_addr (issue_bank_addr),
            .issue_tag       (issue_tag),
            .issue_wdata     (issue_wdata),
            .busy            (bank_busy[i]),
            .rsp_valid       (rsp_valid[i]),
            .rsp_op          (rsp_op[i]),
            .rsp_tag         (rsp_tag[i*`FV_TAG_W +: `FV_TAG_W]),
            .rsp_data        (rsp_data[i*`FV_DATA_W +: `FV_DATA_W])
        );
    end

endmodule

//--- hw/fv_req_fifo.sv
// push while full is dropped and rinc while empty is ignored; read data arrives one cycle after rinc.
`include "fv_mem_consts.svh"

module fv_req_fifo import fv_mem_pkg::*; (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  push,
    input  fv_op_t                push_op,
    input  logic [`FV_ADDR_W-1:0] push_addr,
    input  logic [`FV_TAG_W-1:0]  push_tag,
    input  logic [`FV_DATA_W-1:0] push_wdata,
    input  logic                  rinc,
    output logic                  empty,
    output logic                  full,
    output logic                  valid,
    output fv_op_t                rd_op,
    output logic [`FV_ADDR_W-1:0] rd_addr,
    output logic [`FV_TAG_W-1:0]  rd_tag,
    output logic [`FV_DATA_W-1:0] rd_wdata
);

    localparam int PTR_W = $clog2(`FV_FIFO_DEPTH);

    fv_op_t                buf_op    [`FV_FIFO_DEPTH];
    logic [`FV_ADDR_W-1:0] buf_addr  [`FV_FIFO_DEPTH];
    logic [`FV_TAG_W-1:0]  buf_tag   [`FV_FIFO_DEPTH];
    logic [`FV_DATA_W-1:0] buf_wdata [`FV_FIFO_DEPTH];

    logic [PTR_W-1:0] wptr;
    logic [PTR_W-1:0] rptr;
    logic [PTR_W:0]   count;
    logic             do_push;
    logic             do_pop;

    assign empty   = (count == '0);
    assign full    = (count == (PTR_W + 1)'(`FV_FIFO_DEPTH));
    assign do_push = push && !full;
    assign do_pop  = rinc && !empty;

    // pointers wrap on their own since the depth is a power of two.
    always_ff @(posedge clk) begin
        if (reset) begin
            wptr  <= '0;
            rptr  <= '0;
            count <= '0;
            valid <= 1'b0;
        end else begin
            if (do_push) wptr <= wptr + 1'b1;
            if (do_pop) rptr <= rptr + 1'b1;
            if (do_push && !do_pop) count <= count + 1'b1;
            else if (do_pop && !do_push) count <= count - 1'b1;
            valid <= do_pop;
        end
    end

    always_ff @(posedge clk) begin
        if (do_push) begin
            buf_op[wptr]    <= push_op;
            buf_addr[wptr]  <= push_addr;
            buf_tag[wptr]   <= push_tag;
            buf_wdata[wptr] <= push_wdata;
        end
        if (do_pop) begin
            rd_op    <= buf_op[rptr];
            rd_addr  <= buf_addr[rptr];
            rd_tag   <= buf_tag[rptr];
            rd_wdata <= buf_wdata[rptr];
        end
    end

endmodule

//--- verif/fv_mem_asserts.sv
// bank instances (CHECK_LAT set) check latency; the dispatcher instance checks the FIFO pulse and one-hot issue.
`include "fv_mem_consts.svh"

module fv_mem_asserts #(
    parameter int N         = 1,
    parameter bit CHECK_LAT = 1'b0
) (
    input logic         clk,
    input logic         reset,
    input logic [N-1:0] issue_valid,
    input logic [N-1:0] busy,
    input logic [N-1:0] rsp_valid,
    input logic         fifo_rinc,
    input logic         fifo_empty
);

    a_issue_not_busy: assert property (@(posedge clk) disable iff (reset)
        (issue_valid & busy) == '0)
        else $error("issue strobe sent to a busy bank");

    // the response must land exactly one access time after its issue, and never without one.
    if (CHECK_LAT) begin : g_lat
        for (genvar i = 0; i < N; i++) begin : g_bank
            a_rsp_after_issue: assert property (@(posedge clk) disable iff (reset)
                issue_valid[i] |-> ##(`FV_BANK_LAT) rsp_valid[i])
                else $error("no response one access time after issue");

            a_rsp_has_issue: assert property (@(posedge clk) disable iff (reset)
                rsp_valid[i] |-> $past(issue_valid[i], `FV_BANK_LAT))
                else $error("response without a matching issue");
        end
    end else begin : g_disp
        a_issue_onehot: assert property (@(posedge clk) disable iff (reset)
            $onehot0(issue_valid))
            else $error("more than one issue strobe in the same cycle");

        a_rinc_not_empty: assert property (@(posedge clk) disable iff (reset)
            !(fifo_rinc && fifo_empty))
            else $error("FIFO read pulse while the FIFO is empty");
    end

endmodule

//--- verif/fv_mem_tb.sv
// directed tests on the banked memory; stops at the first mismatch and never pushes while full.
`include "fv_mem_consts.svh"

module fv_mem_tb import fv_mem_pkg::*; ();

    localparam int N_RANDOM   = 200;
    localparam int TOTAL_REQS = 2 + 6 + `FV_NUM_BANKS + 10 + N_RANDOM;
    localparam int ENTRY_W    = 2 + `FV_TAG_W + `FV_DATA_W;

    logic                                clk;
    logic                                reset;
    logic                                req_push;
    fv_op_t                              req_op;
    logic [`FV_ADDR_W-1:0]               req_addr;
    logic [`FV_TAG_W-1:0]                req_tag;
    logic [`FV_DATA_W-1:0]               req_wdata;
    logic                                req_full;
    logic [`FV_NUM_BANKS-1:0]            rsp_valid;
    fv_op_t [`FV_NUM_BANKS-1:0]          rsp_op;
    logic [`FV_NUM_BANKS*`FV_TAG_W-1:0]  rsp_tag;
    logic [`FV_NUM_BANKS*`FV_DATA_W-1:0] rsp_data;

    // reference model: word contents, written flags and per-bank expected responses.
    // an entry is {check data, opcode, tag, data}.
    logic [`FV_DATA_W-1:0] model_mem [2**`FV_ADDR_W];
    bit                    model_written [2**`FV_ADDR_W];
    logic [ENTRY_W-1:0]    exp_q [`FV_NUM_BANKS][$];
    int                    last_rsp_cycle [`FV_NUM_BANKS];
    int                    cycle = 0;
    int                    rsp_count = 0;
    bit                    full_seen = 1'b0;
    logic [31:0]           lfsr = 32'habbfec5f;

    fv_mem_top u_fv_mem_top (
        .clk       (clk),
        .reset     (reset),
        .req_push  (req_push),
        .req_op    (req_op),
        .req_addr  (req_addr),
        .req_tag   (req_tag),
        .req_wdata (req_wdata),
        .req_full  (req_full),
        .rsp_valid (rsp_valid),
        .rsp_op    (rsp_op),
        .rsp_tag   (rsp_tag),
        .rsp_data  (rsp_data)
    );

    bind fv_mem_dispatch fv_mem_asserts #(.N(`FV_NUM_BANKS), .CHECK_LAT(1'b0)) u_disp_asserts (
        .clk (clk), .reset (reset), .issue_valid (issue_valid), .busy (bank_busy),
        .rsp_valid ('0), .fifo_rinc (fifo_rinc), .fifo_empty (fifo_empty)
    );

    bind fv_bank_ctrl fv_mem_asserts #(.N(1), .CHECK_LAT(1'b1)) u_bank_asserts (
        .clk (clk), .reset (reset), .issue_valid (issue_valid), .busy (busy),
        .rsp_valid (rsp_valid), .fifo_rinc (1'b0), .fifo_empty (1'b0)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    always @(posedge clk) cycle <= cycle + 1;

    task automatic compare_values(input logic [63:0] got, input logic [63:0] exp,
                                  input string msg);
        if (got !== exp) begin
            $display("CHECK FAILED at time %0t: %s (got %0h, expected %0h)", $time, msg, got, exp);
            $display("Simulation FAILED");
            $fatal(1, "value mismatch");
        end
    endtask

    // taps 32, 22, 2 and 1.
    function automatic logic lfsr_step();
        logic fb;
        fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
        lfsr = {lfsr[30:0], fb};
        return fb;
    endfunction

    function automatic logic [31:0] lfsr_bits(input int n);
        logic [31:0] r;
        r = '0;
        for (int i = 0; i < n; i++) begin
            r = {r[30:0], lfsr_step()};
        end
        return r;
    endfunction

    // called and returns at 10 units after a rising edge.
    task automatic push_req(input fv_op_t op, input logic [`FV_ADDR_W-1:0] addr,
                            input logic [`FV_TAG_W-1:0] tag, input logic [`FV_DATA_W-1:0] data);
        int bank;
        while (req_full) begin
            req_push = 1'b0;
            @(posedge clk);
            #10;
        end
        bank = addr[`FV_ADDR_W-1:`FV_BANK_ADDR_W];
        if (op == FV_OP_WRITE) begin
            model_mem[addr]     = data;
            model_written[addr] = 1'b1;
        end
        exp_q[bank].push_back({model_written[addr], op, tag, model_mem[addr]});
        req_push  = 1'b1;
        req_op    = op;
        req_addr  = addr;
        req_tag   = tag;
        req_wdata = data;
        @(posedge clk);
        #10;
        req_push = 1'b0;
    endtask

    task automatic wait_drain();
        int pending;
        do begin
            @(posedge clk);
            #10;
            pending = 0;
            for (int b = 0; b < `FV_NUM_BANKS; b++) begin
                pending += exp_q[b].size();
            end
        end while (pending != 0);
    endtask

    // responses are sampled mid-cycle, away from the clock edge.
    always @(negedge clk) begin
        logic [ENTRY_W-1:0] exp_entry;
        if (!reset) begin
            if (req_full) full_seen = 1'b1;
            for (int b = 0; b < `FV_NUM_BANKS; b++) begin
                if (rsp_valid[b] && exp_q[b].size() == 0) begin
                    $display("ERROR: bank %0d responded with no request outstanding at time %0t",
                             b, $time);
                    $display("Simulation FAILED");
                    $fatal(1, "unexpected response");
                end else if (rsp_valid[b]) begin
                    exp_entry = exp_q[b].pop_front();
                    compare_values(rsp_tag[b*`FV_TAG_W +: `FV_TAG_W],
                                   exp_entry[`FV_DATA_W +: `FV_TAG_W],
                                   $sformatf("bank %0d response tag", b));
                    compare_values(rsp_op[b], exp_entry[ENTRY_W-2],
                                   $sformatf("bank %0d response opcode", b));
                    if (exp_entry[ENTRY_W-1]) begin
                        compare_values(rsp_data[b*`FV_DATA_W +: `FV_DATA_W],
                                       exp_entry[`FV_DATA_W-1:0],
                                       $sformatf("bank %0d response data", b));
                    end
                    compare_values(cycle - last_rsp_cycle[b] >= `FV_BANK_LAT + 1, 1'b1,
                                   $sformatf("bank %0d response spacing", b));
                    last_rsp_cycle[b] = cycle;
                    rsp_count++;
                end
            end
        end
    end

    task automatic test_reset();
        reset = 1'b1;
        repeat (5) begin
            @(posedge clk);
            #10;
            compare_values(rsp_valid, '0, "rsp_valid during reset");
            compare_values(req_full, 1'b0, "req_full during reset");
        end
        reset = 1'b0;
        repeat (2) begin
            @(posedge clk);
            #10;
            compare_values(rsp_valid, '0, "rsp_valid after reset");
            compare_values(req_full, 1'b0, "req_full after reset");
        end
    endtask

    task automatic test_write_read();
        push_req(FV_OP_WRITE, 8'h15, 4'd3, 32'hcafe_0123);
        push_req(FV_OP_READ, 8'h15, 4'd4, 32'h0);
        wait_drain();
    endtask

    task automatic test_bank_conflict();
        for (int i = 0; i < 3; i++) begin
            push_req(FV_OP_WRITE, {2'd1, 6'(i * 5)}, 4'(i), lfsr_bits(32));
        end
        for (int i = 0; i < 3; i++) begin
            push_req(FV_OP_READ, {2'd1, 6'(i * 5)}, 4'(i + 8), 32'h0);
        end
        wait_drain();
    endtask

    task automatic test_bank_parallel();
        logic [31:0] r;
        for (int b = 0; b < `FV_NUM_BANKS; b++) begin
            r = lfsr_bits(`FV_BANK_ADDR_W);
            push_req(FV_OP_WRITE, {2'(b), r[`FV_BANK_ADDR_W-1:0]}, 4'(b), lfsr_bits(32));
        end
        wait_drain();
    endtask

    // each read follows the write to the same word.
    task automatic test_back_pressure();
        full_seen = 1'b0;
        for (int i = 0; i < 10; i++) begin
            push_req((i % 2) ? FV_OP_READ : FV_OP_WRITE, {2'd2, 6'(20 + i / 2)}, 4'(i),
                     lfsr_bits(32));
        end
        wait_drain();
        compare_values(full_seen, 1'b1, "req_full rising under back-pressure");
    endtask

    task automatic test_random();
        fv_op_t      op;
        logic [31:0] addr;
        logic [31:0] tag;
        for (int i = 0; i < N_RANDOM; i++) begin
            op   = lfsr_step() ? FV_OP_WRITE : FV_OP_READ;
            addr = lfsr_bits(`FV_ADDR_W);
            tag  = lfsr_bits(`FV_TAG_W);
            push_req(op, addr[`FV_ADDR_W-1:0], tag[`FV_TAG_W-1:0], lfsr_bits(`FV_DATA_W));
        end
        wait_drain();
    endtask

    initial begin
        reset     = 1'b1;
        req_push  = 1'b0;
        req_op    = FV_OP_READ;
        req_addr  = '0;
        req_tag   = '0;
        req_wdata = '0;
        for (int b = 0; b < `FV_NUM_BANKS; b++) begin
            last_rsp_cycle[b] = -100;
        end
        test_reset();
        test_write_read();
        test_bank_conflict();
        test_bank_parallel();
        test_back_pressure();
        test_random();
        $display("Simulation PASSED");
        $finish;
    end

    initial begin
        repeat (TOTAL_REQS * (`FV_BANK_LAT + 6) + 200) @(posedge clk);
        $display("TIMEOUT: responses did not all arrive in time, %0d received", rsp_count);
        $display("Simulation FAILED");
        $fatal(1, "watchdog expired");
    end

endmodule

//--- vlog.f
+incdir+hw
hw/fv_mem_pkg.sv
hw/fv_req_fifo.sv
hw/fv_mem_dispatch.sv
hw/fv_bank_ctrl.sv
hw/fv_mem_top.sv
verif/fv_mem_asserts.sv
verif/fv_mem_tb.sv
